// File: logic/fabric_pkg.sv
// Shared bus widths, address map, response codes and sizes; referenced by scoped name everywhere
`default_nettype none

package fabric_pkg;

    // Bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int RESP_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [RESP_WIDTH-1:0] resp_t;

    // Response codes, AXI encoding
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // Address map
    // Each endpoint owns a 1 KiB window, upper bits pick the endpoint
    localparam int WINDOW_BITS = 10;
    typedef logic [WINDOW_BITS-1:0] local_addr_t;

    localparam addr_t SRAM_BASE = 32'h0001_0000;
    localparam addr_t FIFO_BASE = 32'h0002_0000;

    // SRAM endpoint size in words
    localparam int SRAM_WORDS = 256;

    // FIFO endpoint depth and occupancy
    localparam int FIFO_DEPTH = 8;
    typedef logic [3:0] fifo_count_t;

    // Per-direction request limit for each endpoint
    localparam int MAX_OUTSTANDING = 2;
    typedef logic [1:0] outstanding_t;

endpackage

`default_nettype wire

// File: logic/endpoint_port.sv
// Address match, request admission and outstanding counters in front of one fabric endpoint
`default_nettype none

module endpoint_port #(
    parameter fabric_pkg::addr_t BASE = fabric_pkg::SRAM_BASE
) (
    input  logic                    core_clk,
    input  logic                    cptra_rst_b,

    // Manager side
    input  logic                    aw_valid,
    input  fabric_pkg::addr_t       aw_addr,
    input  logic                    ar_valid,
    input  fabric_pkg::addr_t       ar_addr,
    input  logic                    b_ready,
    input  logic                    r_ready,

    // From the other port
    input  logic                    other_wr_busy,
    input  logic                    other_rd_busy,

    // Endpoint side
    output logic                    ep_aw_valid,
    output fabric_pkg::local_addr_t ep_aw_offset,
    input  logic                    ep_aw_ready,
    output logic                    ep_ar_valid,
    output fabric_pkg::local_addr_t ep_ar_offset,
    input  logic                    ep_ar_ready,
    input  logic                    ep_b_valid,
    output logic                    ep_b_ready,
    input  logic                    ep_r_valid,
    output logic                    ep_r_ready,

    // To the ready merge and response mux
    output logic                    aw_hit_ready,
    output logic                    ar_hit_ready,
    output logic                    wr_busy,
    output logic                    rd_busy
);

    fabric_pkg::outstanding_t wr_cnt;
    fabric_pkg::outstanding_t rd_cnt;
    logic                     aw_hit;
    logic                     ar_hit;
    logic                     aw_admit;
    logic                     ar_admit;
    logic                     aw_hshake;
    logic                     ar_hshake;
    logic                     b_hshake;
    logic                     r_hshake;

    // Up on request, down on response, unchanged when both
    function automatic fabric_pkg::outstanding_t next_count(
        input fabric_pkg::outstanding_t cnt,
        input logic                     req,
        input logic                     rsp
    );
        fabric_pkg::outstanding_t nxt;
        nxt = cnt;
        if (req && !rsp) begin
            nxt = cnt + 1'b1;
        end
        else if (rsp && !req) begin
            nxt = cnt - 1'b1;
        end
        return nxt;
    endfunction

    // Window decode on the upper address bits
    assign aw_hit = aw_addr[fabric_pkg::ADDR_WIDTH-1:fabric_pkg::WINDOW_BITS] ==
                    BASE[fabric_pkg::ADDR_WIDTH-1:fabric_pkg::WINDOW_BITS];
    assign ar_hit = ar_addr[fabric_pkg::ADDR_WIDTH-1:fabric_pkg::WINDOW_BITS] ==
                    BASE[fabric_pkg::ADDR_WIDTH-1:fabric_pkg::WINDOW_BITS];

    // Hold off when full, or when the other endpoint owns this direction
    assign aw_admit = aw_hit && !other_wr_busy &&
                      (wr_cnt < fabric_pkg::outstanding_t'(fabric_pkg::MAX_OUTSTANDING));
    assign ar_admit = ar_hit && !other_rd_busy &&
                      (rd_cnt < fabric_pkg::outstanding_t'(fabric_pkg::MAX_OUTSTANDING));

    assign ep_aw_valid  = aw_valid && aw_admit;
    assign ep_ar_valid  = ar_valid && ar_admit;
    assign ep_aw_offset = aw_addr[fabric_pkg::WINDOW_BITS-1:0];
    assign ep_ar_offset = ar_addr[fabric_pkg::WINDOW_BITS-1:0];
    assign aw_hit_ready = ep_aw_ready && aw_admit;
    assign ar_hit_ready = ep_ar_ready && ar_admit;

    // Response ready only reaches an endpoint that owes a response
    assign ep_b_ready = wr_busy && b_ready;
    assign ep_r_ready = rd_busy && r_ready;

    assign aw_hshake = ep_aw_valid && ep_aw_ready;
    assign ar_hshake = ep_ar_valid && ep_ar_ready;
    assign b_hshake  = ep_b_valid && ep_b_ready;
    assign r_hshake  = ep_r_valid && ep_r_ready;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_cnt <= '0;
            rd_cnt <= '0;
        end
        else begin
            wr_cnt <= next_count(wr_cnt, aw_hshake, b_hshake);
            rd_cnt <= next_count(rd_cnt, ar_hshake, r_hshake);
        end
    end

    assign wr_busy = (wr_cnt != '0);
    assign rd_busy = (rd_cnt != '0);

endmodule

`default_nettype wire

// File: logic/sram_endpoint.sv
// Word memory endpoint with byte strobes; one registered response slot per direction
`default_nettype none

module sram_endpoint (
    input  logic                    core_clk,
    input  logic                    cptra_rst_b,

    // Write request and response
    input  logic                    aw_valid,
    input  fabric_pkg::local_addr_t aw_offset,
    input  fabric_pkg::data_t       w_data,
    input  fabric_pkg::strb_t       w_strb,
    output logic                    aw_ready,
    output logic                    b_valid,
    output fabric_pkg::resp_t       b_resp,
    input  logic                    b_ready,

    // Read request and response
    input  logic                    ar_valid,
    input  fabric_pkg::local_addr_t ar_offset,
    output logic                    ar_ready,
    output logic                    r_valid,
    output fabric_pkg::data_t       r_data,
    input  logic                    r_ready
);

    fabric_pkg::data_t                  mem [fabric_pkg::SRAM_WORDS];
    logic [fabric_pkg::WINDOW_BITS-3:0] wr_index;
    logic [fabric_pkg::WINDOW_BITS-3:0] rd_index;
    logic                               aw_hshake;
    logic                               ar_hshake;

    // Word index from the byte offset
    assign wr_index = aw_offset[fabric_pkg::WINDOW_BITS-1:2];
    assign rd_index = ar_offset[fabric_pkg::WINDOW_BITS-1:2];

    // Slot empty, or draining this cycle
    assign aw_ready  = !b_valid || b_ready;
    assign ar_ready  = !r_valid || r_ready;
    assign aw_hshake = aw_valid && aw_ready;
    assign ar_hshake = ar_valid && ar_ready;

    // Writes always succeed
    assign b_resp = fabric_pkg::RESP_OKAY;

    initial begin
        for (int i = 0; i < fabric_pkg::SRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Only strobed bytes change
    always @(posedge core_clk) begin
        if (aw_hshake) begin
            for (int b = 0; b < fabric_pkg::STRB_WIDTH; b++) begin
                if (w_strb[b]) begin
                    mem[wr_index][b*8 +: 8] <= w_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (ar_hshake) begin
            r_data <= mem[rd_index];
        end
    end

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end
        else begin
            // A new request refills the slot in the cycle it drains
            if (aw_hshake) begin
                b_valid <= 1'b1;
            end
            else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_hshake) begin
                r_valid <= 1'b1;
            end
            else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fifo_endpoint.sv
// Word queue endpoint; writes push, reads pop, overflow and underflow answer SLVERR
`default_nettype none

module fifo_endpoint (
    input  logic              core_clk,
    input  logic              cptra_rst_b,

    // Write request and response
    input  logic              aw_valid,
    input  fabric_pkg::data_t w_data,
    output logic              aw_ready,
    output logic              b_valid,
    output fabric_pkg::resp_t b_resp,
    input  logic              b_ready,

    // Read request and response
    input  logic              ar_valid,
    output logic              ar_ready,
    output logic              r_valid,
    output fabric_pkg::data_t r_data,
    output fabric_pkg::resp_t r_resp,
    input  logic              r_ready
);

    fabric_pkg::data_t                         queue [fabric_pkg::FIFO_DEPTH];
    logic [$clog2(fabric_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(fabric_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    fabric_pkg::fifo_count_t                   count;
    logic                                      full;
    logic                                      empty;
    logic                                      aw_hshake;
    logic                                      ar_hshake;
    logic                                      push;
    logic                                      pop;

    assign full  = (count == fabric_pkg::fifo_count_t'(fabric_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // Slot empty, or draining this cycle
    assign aw_ready  = !b_valid || b_ready;
    assign ar_ready  = !r_valid || r_ready;
    assign aw_hshake = aw_valid && aw_ready;
    assign ar_hshake = ar_valid && ar_ready;

    // Accepted requests that actually move data
    assign push = aw_hshake && !full;
    assign pop  = ar_hshake && !empty;

    always_ff @(posedge core_clk) begin
        if (push) begin
            queue[wr_ptr] <= w_data;
        end
    end

    // Response payload, error when the queue cannot serve
    always_ff @(posedge core_clk) begin
        if (aw_hshake) begin
            b_resp <= full ? fabric_pkg::RESP_SLVERR : fabric_pkg::RESP_OKAY;
        end
        if (ar_hshake) begin
            r_data <= empty ? '0 : queue[rd_ptr];
            r_resp <= empty ? fabric_pkg::RESP_SLVERR : fabric_pkg::RESP_OKAY;
        end
    end

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end
        else begin
            // Depth is a power of two, pointers wrap on their own
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (aw_hshake) begin
                b_valid <= 1'b1;
            end
            else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (ar_hshake) begin
                r_valid <= 1'b1;
            end
            else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/bus_fabric_top.sv
// Fabric top that decodes one manager port onto the SRAM and FIFO endpoints and muxes responses back
`default_nettype none

module bus_fabric_top (
    input  logic              core_clk,
    input  logic              cptra_rst_b,

    // Write request
    input  logic              aw_valid,
    input  fabric_pkg::addr_t aw_addr,
    input  fabric_pkg::data_t w_data,
    input  fabric_pkg::strb_t w_strb,
    output logic              aw_ready,

    // Write response
    output logic              b_valid,
    output fabric_pkg::resp_t b_resp,
    input  logic              b_ready,

    // Read request
    input  logic              ar_valid,
    input  fabric_pkg::addr_t ar_addr,
    output logic              ar_ready,

    // Read response
    output logic              r_valid,
    output fabric_pkg::data_t r_data,
    output fabric_pkg::resp_t r_resp,
    input  logic              r_ready
);

    // SRAM path
    logic                    sram_aw_valid;
    fabric_pkg::local_addr_t sram_aw_offset;
    logic                    sram_aw_ready;
    logic                    sram_ar_valid;
    fabric_pkg::local_addr_t sram_ar_offset;
    logic                    sram_ar_ready;
    logic                    sram_b_valid;
    logic                    sram_b_ready;
    fabric_pkg::resp_t       sram_b_resp;
    logic                    sram_r_valid;
    logic                    sram_r_ready;
    fabric_pkg::data_t       sram_r_data;
    logic                    sram_aw_hit_ready;
    logic                    sram_ar_hit_ready;
    logic                    sram_wr_busy;
    logic                    sram_rd_busy;

    // FIFO path
    logic                    fifo_aw_valid;
    logic                    fifo_aw_ready;
    logic                    fifo_ar_valid;
    logic                    fifo_ar_ready;
    logic                    fifo_b_valid;
    logic                    fifo_b_ready;
    fabric_pkg::resp_t       fifo_b_resp;
    logic                    fifo_r_valid;
    logic                    fifo_r_ready;
    fabric_pkg::data_t       fifo_r_data;
    fabric_pkg::resp_t       fifo_r_resp;
    logic                    fifo_aw_hit_ready;
    logic                    fifo_ar_hit_ready;
    logic                    fifo_wr_busy;
    logic                    fifo_rd_busy;

    // Busy flags cross over so only one endpoint owns each direction
    endpoint_port #(.BASE(fabric_pkg::SRAM_BASE)) sram_port (
        .core_clk     (core_clk),
        .cptra_rst_b  (cptra_rst_b),
        .aw_valid     (aw_valid),
        .aw_addr      (aw_addr),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .b_ready      (b_ready),
        .r_ready      (r_ready),
        .other_wr_busy(fifo_wr_busy),
        .other_rd_busy(fifo_rd_busy),
        .ep_aw_valid  (sram_aw_valid),
        .ep_aw_offset (sram_aw_offset),
        .ep_aw_ready  (sram_aw_ready),
        .ep_ar_valid  (sram_ar_valid),
        .ep_ar_offset (sram_ar_offset),
        .ep_ar_ready  (sram_ar_ready),
        .ep_b_valid   (sram_b_valid),
        .ep_b_ready   (sram_b_ready),
        .ep_r_valid   (sram_r_valid),
        .ep_r_ready   (sram_r_ready),
        .aw_hit_ready (sram_aw_hit_ready),
        .ar_hit_ready (sram_ar_hit_ready),
        .wr_busy      (sram_wr_busy),
        .rd_busy      (sram_rd_busy)
    );

    // The queue ignores offsets
    endpoint_port #(.BASE(fabric_pkg::FIFO_BASE)) fifo_port (
        .core_clk     (core_clk),
        .cptra_rst_b  (cptra_rst_b),
        .aw_valid     (aw_valid),
        .aw_addr      (aw_addr),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .b_ready      (b_ready),
        .r_ready      (r_ready),
        .other_wr_busy(sram_wr_busy),
        .other_rd_busy(sram_rd_busy),
        .ep_aw_valid  (fifo_aw_valid),
        .ep_aw_offset (),
        .ep_aw_ready  (fifo_aw_ready),
        .ep_ar_valid  (fifo_ar_valid),
        .ep_ar_offset (),
        .ep_ar_ready  (fifo_ar_ready),
        .ep_b_valid   (fifo_b_valid),
        .ep_b_ready   (fifo_b_ready),
        .ep_r_valid   (fifo_r_valid),
        .ep_r_ready   (fifo_r_ready),
        .aw_hit_ready (fifo_aw_hit_ready),
        .ar_hit_ready (fifo_ar_hit_ready),
        .wr_busy      (fifo_wr_busy),
        .rd_busy      (fifo_rd_busy)
    );

    sram_endpoint u_sram (
        .core_clk   (core_clk),
        .cptra_rst_b(cptra_rst_b),
        .aw_valid   (sram_aw_valid),
        .aw_offset  (sram_aw_offset),
        .w_data     (w_data),
        .w_strb     (w_strb),
        .aw_ready   (sram_aw_ready),
        .b_valid    (sram_b_valid),
        .b_resp     (sram_b_resp),
        .b_ready    (sram_b_ready),
        .ar_valid   (sram_ar_valid),
        .ar_offset  (sram_ar_offset),
        .ar_ready   (sram_ar_ready),
        .r_valid    (sram_r_valid),
        .r_data     (sram_r_data),
        .r_ready    (sram_r_ready)
    );

    fifo_endpoint u_fifo (
        .core_clk   (core_clk),
        .cptra_rst_b(cptra_rst_b),
        .aw_valid   (fifo_aw_valid),
        .w_data     (w_data),
        .aw_ready   (fifo_aw_ready),
        .b_valid    (fifo_b_valid),
        .b_resp     (fifo_b_resp),
        .b_ready    (fifo_b_ready),
        .ar_valid   (fifo_ar_valid),
        .ar_ready   (fifo_ar_ready),
        .r_valid    (fifo_r_valid),
        .r_data     (fifo_r_data),
        .r_resp     (fifo_r_resp),
        .r_ready    (fifo_r_ready)
    );

    // Unmapped addresses leave both contributions low
    assign aw_ready = sram_aw_hit_ready || fifo_aw_hit_ready;
    assign ar_ready = sram_ar_hit_ready || fifo_ar_hit_ready;

    // At most one endpoint is busy per direction
    always_comb begin
        b_valid = sram_wr_busy ? sram_b_valid :
                  fifo_wr_busy ? fifo_b_valid : 1'b0;
        b_resp  = sram_wr_busy ? sram_b_resp :
                  fifo_wr_busy ? fifo_b_resp : '0;

        // SRAM reads never fail
        r_valid = sram_rd_busy ? sram_r_valid :
                  fifo_rd_busy ? fifo_r_valid : 1'b0;
        r_data  = sram_rd_busy ? sram_r_data :
                  fifo_rd_busy ? fifo_r_data : '0;
        r_resp  = sram_rd_busy ? fabric_pkg::RESP_OKAY :
                  fifo_rd_busy ? fifo_r_resp : '0;
    end

endmodule

`default_nettype wire

// File: verification/fabric_tb_table.svh
// Stimulus rows and expected results for the fabric testbench, included inside its top module
`ifndef FABRIC_TB_TABLE_SVH
`define FABRIC_TB_TABLE_SVH

typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_UNMAPPED
} op_e;

typedef struct packed {
    op_e               op;
    fabric_pkg::addr_t addr;
    fabric_pkg::data_t data;
    fabric_pkg::strb_t strb;
    fabric_pkg::data_t exp_data;
    fabric_pkg::resp_t exp_resp;
} table_row_t;

// Bus response encoding
localparam logic [1:0] RSP_OK  = 2'd0;
localparam logic [1:0] RSP_ERR = 2'd2;

localparam int NUM_ROWS = 34;

// op, address, write data, strobes, expected read data, expected response
localparam table_row_t STIMULUS [NUM_ROWS] = '{
    // SRAM full words
    '{OP_WRITE,    32'h0001_0000, 32'h1122_3344, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0001_0004, 32'hdead_beef, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0001_03fc, 32'ha5a5_5a5a, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_READ,     32'h0001_0000, 32'h0000_0000, 4'h0, 32'h1122_3344, RSP_OK},
    '{OP_READ,     32'h0001_0004, 32'h0000_0000, 4'h0, 32'hdead_beef, RSP_OK},
    '{OP_READ,     32'h0001_03fc, 32'h0000_0000, 4'h0, 32'ha5a5_5a5a, RSP_OK},
    // Bytes 0 and 2 only
    '{OP_WRITE,    32'h0001_0004, 32'h0011_2233, 4'h5, 32'h0000_0000, RSP_OK},
    '{OP_READ,     32'h0001_0004, 32'h0000_0000, 4'h0, 32'hde11_be33, RSP_OK},
    // FIFO order, then underflow
    '{OP_WRITE,    32'h0002_0000, 32'h0000_0001, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0004, 32'h0000_0002, 4'h3, 32'h0000_0000, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'h0000_0001, RSP_OK},
    '{OP_READ,     32'h0002_0008, 32'h0000_0000, 4'h0, 32'h0000_0002, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, RSP_ERR},
    // Nine pushes, the last overflows
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0001, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0002, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0003, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0004, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0005, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0006, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0007, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0008, 4'hf, 32'h0000_0000, RSP_OK},
    '{OP_WRITE,    32'h0002_0000, 32'hc0de_0009, 4'hf, 32'h0000_0000, RSP_ERR},
    // Drain, first eight come back
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0001, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0002, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0003, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0004, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0005, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0006, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0007, RSP_OK},
    '{OP_READ,     32'h0002_0000, 32'h0000_0000, 4'h0, 32'hc0de_0008, RSP_OK},
    // Unmapped read is never taken, SRAM still answers after it
    '{OP_UNMAPPED, 32'h0003_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, RSP_OK},
    '{OP_READ,     32'h0001_0000, 32'h0000_0000, 4'h0, 32'h1122_3344, RSP_OK},
    // Untouched word starts at zero, top byte only
    '{OP_WRITE,    32'h0001_0008, 32'h7700_00ff, 4'h8, 32'h0000_0000, RSP_OK},
    '{OP_READ,     32'h0001_0008, 32'h0000_0000, 4'h0, 32'h7700_0000, RSP_OK}
};

`endif

// File: verification/bus_fabric_tb.sv
// Testbench for the bus fabric top; applies the table rows with random response back-pressure
`default_nettype none

module bus_fabric_tb;

    localparam int TIMEOUT_CYCLES  = 50;
    localparam int UNMAPPED_CYCLES = 20;
    localparam int WAIT_AW_READY   = 0;
    localparam int WAIT_AR_READY   = 1;
    localparam int WAIT_B_VALID    = 2;
    localparam int WAIT_R_VALID    = 3;

    logic              core_clk;
    logic              cptra_rst_b;
    logic              aw_valid;
    fabric_pkg::addr_t aw_addr;
    fabric_pkg::data_t w_data;
    fabric_pkg::strb_t w_strb;
    logic              aw_ready;
    logic              b_valid;
    fabric_pkg::resp_t b_resp;
    logic              b_ready;
    logic              ar_valid;
    fabric_pkg::addr_t ar_addr;
    logic              ar_ready;
    logic              r_valid;
    fabric_pkg::data_t r_data;
    fabric_pkg::resp_t r_resp;
    logic              r_ready;

    int          errors;
    int          timeouts;
    logic [31:0] lfsr_state;

    `include "fabric_tb_table.svh"

    bus_fabric_top dut (
        .core_clk   (core_clk),
        .cptra_rst_b(cptra_rst_b),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .w_data     (w_data),
        .w_strb     (w_strb),
        .aw_ready   (aw_ready),
        .b_valid    (b_valid),
        .b_resp     (b_resp),
        .b_ready    (b_ready),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .r_resp     (r_resp),
        .r_ready    (r_ready)
    );

    initial begin
        core_clk = 1'b0;
    end

    always begin
        #2 core_clk = ~core_clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAILED %s: expected %h, got %h", name, expected, actual);
    endtask

    function automatic logic sample_flag(input int which);
        case (which)
            WAIT_AW_READY: return aw_ready;
            WAIT_AR_READY: return ar_ready;
            WAIT_B_VALID:  return b_valid;
            default:       return r_valid;
        endcase
    endfunction

    // Samples on falling edges and returns -1 cycles on timeout
    task automatic wait_for(input int which, input string what, output int cycles);
        cycles = 0;
        @(negedge core_clk);
        while (!sample_flag(which) && cycles < TIMEOUT_CYCLES) begin
            @(negedge core_clk);
            cycles++;
        end
        if (!sample_flag(which)) begin
            timeouts++;
            $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
            cycles = -1;
        end
    endtask

    task automatic send_write(input fabric_pkg::addr_t addr, input fabric_pkg::data_t data,
                              input fabric_pkg::strb_t strb);
        int cycles;
        @(posedge core_clk);
        aw_valid <= 1'b1;
        aw_addr  <= addr;
        w_data   <= data;
        w_strb   <= strb;
        wait_for(WAIT_AW_READY, "aw_ready", cycles);
        @(posedge core_clk);
        aw_valid <= 1'b0;
    endtask

    task automatic send_read(input fabric_pkg::addr_t addr);
        int cycles;
        @(posedge core_clk);
        ar_valid <= 1'b1;
        ar_addr  <= addr;
        wait_for(WAIT_AR_READY, "ar_ready", cycles);
        @(posedge core_clk);
        ar_valid <= 1'b0;
    endtask

    // Holds b_ready low for a random 0 to 7 cycles while the response stays put
    task automatic take_write(input fabric_pkg::resp_t exp_resp);
        int                idle;
        int                cycles;
        fabric_pkg::resp_t held_resp;
        draw_bits(3, idle);
        wait_for(WAIT_B_VALID, "b_valid", cycles);
        if (cycles >= 0) begin
            // Response valid one edge after the request
            assert (cycles == 0) else begin
                errors++;
                $display("Write response arrived %0d cycles late", cycles);
            end
            held_resp = b_resp;
            for (int i = 0; i <= idle; i++) begin
                if (i == idle) begin
                    @(posedge core_clk);
                    b_ready <= 1'b1;
                end
                @(negedge core_clk);
                assert (b_valid) else report_mismatch("b_valid", 32'd1, 32'(b_valid));
                assert (b_resp == held_resp)
                    else report_mismatch("b_resp", 32'(held_resp), 32'(b_resp));
            end
            assert (b_resp == exp_resp)
                else report_mismatch("b_resp", 32'(exp_resp), 32'(b_resp));
            @(posedge core_clk);
            b_ready <= 1'b0;
        end
    endtask

    task automatic take_read(input fabric_pkg::data_t exp_data, input fabric_pkg::resp_t exp_resp);
        int                idle;
        int                cycles;
        fabric_pkg::data_t held_data;
        fabric_pkg::resp_t held_resp;
        draw_bits(3, idle);
        wait_for(WAIT_R_VALID, "r_valid", cycles);
        if (cycles >= 0) begin
            assert (cycles == 0) else begin
                errors++;
                $display("Read response arrived %0d cycles late", cycles);
            end
            held_data = r_data;
            held_resp = r_resp;
            for (int i = 0; i <= idle; i++) begin
                if (i == idle) begin
                    @(posedge core_clk);
                    r_ready <= 1'b1;
                end
                @(negedge core_clk);
                assert (r_valid) else report_mismatch("r_valid", 32'd1, 32'(r_valid));
                assert (r_data == held_data) else report_mismatch("r_data", held_data, r_data);
                assert (r_resp == held_resp)
                    else report_mismatch("r_resp", 32'(held_resp), 32'(r_resp));
            end
            assert (r_data == exp_data) else report_mismatch("r_data", exp_data, r_data);
            assert (r_resp == exp_resp)
                else report_mismatch("r_resp", 32'(exp_resp), 32'(r_resp));
            @(posedge core_clk);
            r_ready <= 1'b0;
        end
    endtask

    // No endpoint claims the address and the request is withdrawn unanswered
    task automatic hold_unmapped_read(input fabric_pkg::addr_t addr);
        @(posedge core_clk);
        ar_valid <= 1'b1;
        ar_addr  <= addr;
        repeat (UNMAPPED_CYCLES) begin
            @(negedge core_clk);
            assert (!ar_ready) else report_mismatch("ar_ready", 32'd0, 32'(ar_ready));
            assert (!r_valid) else report_mismatch("r_valid", 32'd0, 32'(r_valid));
        end
        @(posedge core_clk);
        ar_valid <= 1'b0;
    endtask

    initial begin
        errors      = 0;
        timeouts    = 0;
        lfsr_state  = 32'hd475bafa;
        cptra_rst_b = 1'b0;
        aw_valid    = 1'b0;
        aw_addr     = '0;
        w_data      = '0;
        w_strb      = '0;
        b_ready     = 1'b0;
        ar_valid    = 1'b0;
        ar_addr     = '0;
        r_ready     = 1'b0;

        repeat (10) @(posedge core_clk);
        cptra_rst_b <= 1'b1;
        @(negedge core_clk);
        assert (!aw_ready) else report_mismatch("aw_ready", 32'd0, 32'(aw_ready));
        assert (!ar_ready) else report_mismatch("ar_ready", 32'd0, 32'(ar_ready));
        assert (!b_valid) else report_mismatch("b_valid", 32'd0, 32'(b_valid));
        assert (!r_valid) else report_mismatch("r_valid", 32'd0, 32'(r_valid));

        // Rows stop at the first timeout
        for (int i = 0; i < NUM_ROWS && timeouts == 0; i++) begin
            case (STIMULUS[i].op)
                OP_WRITE: begin
                    send_write(STIMULUS[i].addr, STIMULUS[i].data, STIMULUS[i].strb);
                    if (timeouts == 0) begin
                        take_write(STIMULUS[i].exp_resp);
                    end
                end
                OP_READ: begin
                    send_read(STIMULUS[i].addr);
                    if (timeouts == 0) begin
                        take_read(STIMULUS[i].exp_data, STIMULUS[i].exp_resp);
                    end
                end
                default: begin
                    hold_unmapped_read(STIMULUS[i].addr);
                end
            endcase
        end

        $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
logic/fabric_pkg.sv
logic/endpoint_port.sv
logic/sram_endpoint.sv
logic/fifo_endpoint.sv
logic/bus_fabric_top.sv
verification/bus_fabric_tb.sv

// File: Makefile
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := bus_fabric_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed

SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/fabric_tb_table.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
